// File: hw/rv_cfg.svh
// RV32I core configuration
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

`define RV_XLEN      32
`define RV_ILEN      32
`define RV_NREGS     32
`define RV_REG_AW    5

// First fetch address after reset
`define RV_RESET_PC  32'h0000_0000

//////////////////////////////
// Major opcodes
//////////////////////////////

`define RV_OP_OP     7'b0110011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011

`endif

// File: hw/rv_pkg.sv
// RV32I core types
`include "rv_cfg.svh"

package rv_pkg;

    // Plain vectors
    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_ILEN-1:0]   inst_t;
    typedef logic [`RV_REG_AW-1:0] reg_idx_t;

    // ALU function, compares included
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_EQ,
        ALU_NE,
        ALU_LT
    } alu_op_e;

    // Writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_IMM
    } wb_sel_e;

    // Fetch stall FSM
    typedef enum logic [1:0] {
        RUN,
        WAIT1,
        WAIT2
    } fetch_state_e;

endpackage

// File: hw/rv_stage_if.sv
// Pipeline stage interfaces
`timescale 1ns/10ps

// Decode to execute
interface id_ex_if import rv_pkg::*; ();
    logic     valid;
    word_t    pc;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
    alu_op_e  alu_op;
    logic     a_is_pc_zero;
    logic     b_is_imm;
    logic     is_branch;
    logic     mem_we;
    logic     rf_we;
    wb_sel_e  wb_sel;

    modport producer (
        output valid, pc, rs1_val, rs2_val, imm, rs1_idx, rs2_idx, rd_idx,
               alu_op, a_is_pc_zero, b_is_imm, is_branch, mem_we, rf_we, wb_sel
    );
    modport consumer (
        input  valid, pc, rs1_val, rs2_val, imm, rs1_idx, rs2_idx, rd_idx,
               alu_op, a_is_pc_zero, b_is_imm, is_branch, mem_we, rf_we, wb_sel
    );
endinterface

// Execute to memory, with the forwarding value coming back
interface ex_mem_if import rv_pkg::*; ();
    logic     valid;
    word_t    pc;
    word_t    alu_res;
    word_t    store_data;
    word_t    imm;
    reg_idx_t rd_idx;
    logic     mem_we;
    logic     rf_we;
    wb_sel_e  wb_sel;
    word_t    mem_result;

    modport producer (
        output valid, pc, alu_res, store_data, imm, rd_idx, mem_we, rf_we, wb_sel,
        input  mem_result
    );
    modport consumer (
        input  valid, pc, alu_res, store_data, imm, rd_idx, mem_we, rf_we, wb_sel,
        output mem_result
    );
endinterface

// Writeback bundle
interface wb_if import rv_pkg::*; ();
    logic     valid;
    word_t    pc;
    logic     rf_we;
    reg_idx_t rd_idx;
    word_t    data;

    modport producer (output valid, pc, rf_we, rd_idx, data);
    modport consumer (input  valid, pc, rf_we, rd_idx, data);
endinterface

// File: hw/rv_fetch.sv
// RV32I fetch stage
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_fetch import rv_pkg::*; (
    input  logic  clk_cpu_i,
    input  logic  arst_n_i,
    input  inst_t irom_inst_i,
    input  word_t next_pc_i,
    output word_t irom_addr_o,
    output logic  id_valid_o,
    output word_t id_pc_o,
    output inst_t id_inst_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    word_t        pc_q;
    word_t        pc_d;
    logic         fetched_branch;

    assign fetched_branch = (irom_inst_i[6:0] == `RV_OP_BRANCH);
    assign irom_addr_o    = pc_q;

    //////////////////////////////
    // Branch stall FSM
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q + word_t'(4);
        case (state_q)
            RUN: begin
                if (fetched_branch) begin
                    state_d = WAIT1;
                    pc_d    = pc_q;
                end
            end
            WAIT1: begin
                state_d = WAIT2;
                pc_d    = pc_q;
            end
            // Branch resolves in execute this cycle
            WAIT2: begin
                state_d = RUN;
                pc_d    = next_pc_i;
            end
            default: begin
                state_d = RUN;
                pc_d    = pc_q;
            end
        endcase
    end

    always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= RUN;
            pc_q       <= `RV_RESET_PC;
            id_valid_o <= 1'b0;
        end else begin
            state_q    <= state_d;
            pc_q       <= pc_d;
            id_valid_o <= (state_q == RUN);
        end
    end

    // IF/ID payload
    always_ff @(posedge clk_cpu_i) begin
        id_pc_o   <= pc_q;
        id_inst_o <= irom_inst_i;
    end

endmodule

// File: hw/rv_decode.sv
// RV32I decode stage
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_decode import rv_pkg::*; (
    input  logic      clk_cpu_i,
    input  logic      arst_n_i,
    input  logic      id_valid_i,
    input  word_t     id_pc_i,
    input  inst_t     id_inst_i,
    wb_if.consumer    wb,
    id_ex_if.producer ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm;
    alu_op_e    alu_op;
    wb_sel_e    wb_sel;
    logic       a_zero;
    logic       b_imm;
    logic       is_branch;
    logic       mem_we;
    logic       rf_we;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      regs [`RV_NREGS];

    assign opcode = id_inst_i[6:0];
    assign funct3 = id_inst_i[14:12];
    assign rd     = id_inst_i[11:7];
    assign rs1    = id_inst_i[19:15];
    assign rs2    = id_inst_i[24:20];

    function automatic alu_op_e alu_fn(logic [2:0] f3, logic sub);
        alu_op_e op;
        case (f3)
            3'b000:  op = sub ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b100:  op = ALU_XOR;
            3'b101:  op = ALU_SRL;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    //////////////////////////////
    // Control and immediate
    //////////////////////////////

    always_comb begin
        alu_op    = ALU_ADD;
        wb_sel    = WB_ALU;
        a_zero    = 1'b0;
        b_imm     = 1'b0;
        is_branch = 1'b0;
        mem_we    = 1'b0;
        rf_we     = 1'b0;
        imm       = {{20{id_inst_i[31]}}, id_inst_i[31:20]};
        case (opcode)
            `RV_OP_OP: begin
                rf_we  = 1'b1;
                alu_op = alu_fn(funct3, id_inst_i[30]);
            end
            `RV_OP_OP_IMM: begin
                rf_we  = 1'b1;
                b_imm  = 1'b1;
                alu_op = alu_fn(funct3, 1'b0);
            end
            `RV_OP_LUI: begin
                rf_we  = 1'b1;
                a_zero = 1'b1;
                b_imm  = 1'b1;
                wb_sel = WB_IMM;
                imm    = {id_inst_i[31:12], 12'h000};
            end
            `RV_OP_LOAD: begin
                rf_we  = 1'b1;
                b_imm  = 1'b1;
                wb_sel = WB_MEM;
            end
            `RV_OP_STORE: begin
                mem_we = 1'b1;
                b_imm  = 1'b1;
                imm    = {{20{id_inst_i[31]}}, id_inst_i[31:25], id_inst_i[11:7]};
            end
            `RV_OP_BRANCH: begin
                is_branch = 1'b1;
                imm = {{20{id_inst_i[31]}}, id_inst_i[7], id_inst_i[30:25],
                       id_inst_i[11:8], 1'b0};
                case (funct3)
                    3'b000:  alu_op = ALU_EQ;
                    3'b001:  alu_op = ALU_NE;
                    default: alu_op = ALU_LT;
                endcase
            end
            default: ;
        endcase
    end

    //////////////////////////////
    // Register file
    //////////////////////////////

    // x0 reads zero, writeback in the same cycle is passed through
    function automatic word_t rf_read(reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb.valid && wb.rf_we && wb.rd_idx == idx) begin
            val = wb.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = rf_read(rs1);
        rs2_val = rf_read(rs2);
    end

    always_ff @(posedge clk_cpu_i) begin
        if (wb.valid && wb.rf_we && wb.rd_idx != '0) begin
            regs[wb.rd_idx] <= wb.data;
        end
    end

    // ID/EX register
    always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex.valid     <= 1'b0;
            ex.rf_we     <= 1'b0;
            ex.mem_we    <= 1'b0;
            ex.is_branch <= 1'b0;
        end else begin
            ex.valid     <= id_valid_i;
            ex.rf_we     <= rf_we & id_valid_i;
            ex.mem_we    <= mem_we & id_valid_i;
            ex.is_branch <= is_branch & id_valid_i;
        end
    end

    always_ff @(posedge clk_cpu_i) begin
        ex.pc           <= id_pc_i;
        ex.rs1_val      <= rs1_val;
        ex.rs2_val      <= rs2_val;
        ex.imm          <= imm;
        ex.rs1_idx      <= rs1;
        ex.rs2_idx      <= rs2;
        ex.rd_idx       <= rd;
        ex.alu_op       <= alu_op;
        ex.a_is_pc_zero <= a_zero;
        ex.b_is_imm     <= b_imm;
        ex.wb_sel       <= wb_sel;
    end

endmodule

// File: hw/rv_execute.sv
// RV32I execute stage
`timescale 1ns/10ps

module rv_execute import rv_pkg::*; (
    input  logic      clk_cpu_i,
    input  logic      arst_n_i,
    id_ex_if.consumer ex,
    ex_mem_if.producer mem,
    wb_if.consumer    wb,
    output word_t     next_pc_o
);

    word_t fwd_rs1;
    word_t fwd_rs2;
    word_t op_a;
    word_t op_b;
    word_t alu_res;
    logic  lt;
    logic  cmp;

    //////////////////////////////
    // Operand forwarding
    //////////////////////////////

    // Memory stage wins over writeback, it is the younger result
    function automatic word_t fwd(reg_idx_t idx, word_t dec_val);
        word_t val;
        if (mem.rf_we && mem.rd_idx != '0 && mem.rd_idx == idx) begin
            val = mem.mem_result;
        end else if (wb.rf_we && wb.rd_idx != '0 && wb.rd_idx == idx) begin
            val = wb.data;
        end else begin
            val = dec_val;
        end
        return val;
    endfunction

    always_comb begin
        fwd_rs1 = fwd(ex.rs1_idx, ex.rs1_val);
        fwd_rs2 = fwd(ex.rs2_idx, ex.rs2_val);
    end

    assign op_a = ex.a_is_pc_zero ? '0 : fwd_rs1;
    assign op_b = ex.b_is_imm ? ex.imm : fwd_rs2;

    //////////////////////////////
    // ALU
    //////////////////////////////

    assign lt = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (ex.alu_op)
            ALU_EQ:  cmp = (op_a == op_b);
            ALU_NE:  cmp = (op_a != op_b);
            default: cmp = lt;
        endcase
    end

    always_comb begin
        case (ex.alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = word_t'(lt);
            ALU_SLL: alu_res = op_a << op_b[4:0];
            ALU_SRL: alu_res = op_a >> op_b[4:0];
            default: alu_res = word_t'(cmp);
        endcase
    end

    // Fetch only samples this while it waits on a branch
    assign next_pc_o = (ex.valid && ex.is_branch && cmp) ? ex.pc + ex.imm
                                                          : ex.pc + word_t'(4);

    // EX/MEM register
    always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem.valid  <= 1'b0;
            mem.rf_we  <= 1'b0;
            mem.mem_we <= 1'b0;
        end else begin
            mem.valid  <= ex.valid;
            mem.rf_we  <= ex.rf_we;
            mem.mem_we <= ex.mem_we;
        end
    end

    always_ff @(posedge clk_cpu_i) begin
        mem.pc         <= ex.pc;
        mem.alu_res    <= alu_res;
        mem.store_data <= fwd_rs2;
        mem.imm        <= ex.imm;
        mem.rd_idx     <= ex.rd_idx;
        mem.wb_sel     <= ex.wb_sel;
    end

endmodule

// File: hw/rv_mem_wb.sv
// RV32I memory and writeback stages
`timescale 1ns/10ps

module rv_mem_wb import rv_pkg::*; (
    input  logic       clk_cpu_i,
    input  logic       arst_n_i,
    input  word_t      dram_rdata_i,
    ex_mem_if.consumer mem,
    wb_if.producer     wb,
    output word_t      dram_addr_o,
    output word_t      dram_wdata_o,
    output logic       dram_we_o
);

    //////////////////////////////
    // Data RAM port
    //////////////////////////////

    assign dram_addr_o  = mem.alu_res;
    assign dram_wdata_o = mem.store_data;
    assign dram_we_o    = mem.mem_we;

    // Writeback value, also fed back to execute
    always_comb begin
        case (mem.wb_sel)
            WB_MEM:  mem.mem_result = dram_rdata_i;
            WB_IMM:  mem.mem_result = mem.imm;
            default: mem.mem_result = mem.alu_res;
        endcase
    end

    // MEM/WB register
    always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb.valid <= 1'b0;
            wb.rf_we <= 1'b0;
        end else begin
            wb.valid <= mem.valid;
            wb.rf_we <= mem.rf_we;
        end
    end

    always_ff @(posedge clk_cpu_i) begin
        wb.pc     <= mem.pc;
        wb.rd_idx <= mem.rd_idx;
        wb.data   <= mem.mem_result;
    end

endmodule

// File: hw/rv_core.sv
// RV32I five-stage pipeline
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
    input  logic     clk_cpu_i,
    input  logic     arst_n_i,
    input  inst_t    irom_inst_i,
    input  word_t    dram_rdata_i,
    output word_t    irom_addr_o,
    output word_t    dram_addr_o,
    output word_t    dram_wdata_o,
    output logic     dram_we_o,
    // Retire trace
    output logic     debug_wb_have_inst_o,
    output word_t    debug_wb_pc_o,
    output logic     debug_wb_ena_o,
    output reg_idx_t debug_wb_reg_o,
    output word_t    debug_wb_value_o
);

    logic  if_id_valid;
    word_t if_id_pc;
    inst_t if_id_inst;
    word_t next_pc;

    id_ex_if  id_ex_bus ();
    ex_mem_if ex_mem_bus ();
    wb_if     wb_bus ();

    //////////////////////////////
    // Stages
    //////////////////////////////

    rv_fetch u_fetch_0 (
        .clk_cpu_i   (clk_cpu_i),
        .arst_n_i    (arst_n_i),
        .irom_inst_i (irom_inst_i),
        .next_pc_i   (next_pc),
        .irom_addr_o (irom_addr_o),
        .id_valid_o  (if_id_valid),
        .id_pc_o     (if_id_pc),
        .id_inst_o   (if_id_inst)
    );

    rv_decode u_decode_0 (
        .clk_cpu_i  (clk_cpu_i),
        .arst_n_i   (arst_n_i),
        .id_valid_i (if_id_valid),
        .id_pc_i    (if_id_pc),
        .id_inst_i  (if_id_inst),
        .wb         (wb_bus.consumer),
        .ex         (id_ex_bus.producer)
    );

    rv_execute u_execute_0 (
        .clk_cpu_i (clk_cpu_i),
        .arst_n_i  (arst_n_i),
        .ex        (id_ex_bus.consumer),
        .mem       (ex_mem_bus.producer),
        .wb        (wb_bus.consumer),
        .next_pc_o (next_pc)
    );

    rv_mem_wb u_mem_wb_0 (
        .clk_cpu_i    (clk_cpu_i),
        .arst_n_i     (arst_n_i),
        .dram_rdata_i (dram_rdata_i),
        .mem          (ex_mem_bus.consumer),
        .wb           (wb_bus.producer),
        .dram_addr_o  (dram_addr_o),
        .dram_wdata_o (dram_wdata_o),
        .dram_we_o    (dram_we_o)
    );

    // Debug trace straight off the writeback bundle
    assign debug_wb_have_inst_o = wb_bus.valid;
    assign debug_wb_pc_o        = wb_bus.pc;
    assign debug_wb_ena_o       = wb_bus.rf_we;
    assign debug_wb_reg_o       = wb_bus.rd_idx;
    assign debug_wb_value_o     = wb_bus.data;

endmodule

// File: tb/tb_programs.svh
// Test program encoders and loaders

localparam logic [2:0] f3_add = 3'b000;
localparam logic [2:0] f3_sll = 3'b001;
localparam logic [2:0] f3_slt = 3'b010;
localparam logic [2:0] f3_xor = 3'b100;
localparam logic [2:0] f3_srl = 3'b101;
localparam logic [2:0] f3_or  = 3'b110;
localparam logic [2:0] f3_and = 3'b111;
localparam logic [2:0] f3_beq = 3'b000;
localparam logic [2:0] f3_bne = 3'b001;
localparam logic [2:0] f3_blt = 3'b100;
localparam logic [6:0] f7_alt = 7'b0100000;

//////////////////////////////
// Instruction formats
//////////////////////////////

function automatic inst_t rtype(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
endfunction

function automatic inst_t itype(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                logic [11:0] imm);
    return {imm, rs1, f3, rd, `RV_OP_OP_IMM};
endfunction

function automatic inst_t utype(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, `RV_OP_LUI};
endfunction

function automatic inst_t lw_inst(reg_idx_t rd, reg_idx_t rs1, logic [11:0] off);
    return {off, rs1, 3'b010, rd, `RV_OP_LOAD};
endfunction

function automatic inst_t sw_inst(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], `RV_OP_STORE};
endfunction

function automatic inst_t btype(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
endfunction

//////////////////////////////
// Program loaders
//////////////////////////////

task automatic load_alu_chain();
    clear_rom();
    emit(utype(5'd1, 20'h12345));
    emit(itype(f3_add, 5'd2, 5'd1, 12'h678));
    emit(rtype(7'd0, f3_add, 5'd3, 5'd2, 5'd1));
    emit(rtype(f7_alt, f3_add, 5'd4, 5'd3, 5'd2));
    emit(rtype(7'd0, f3_xor, 5'd5, 5'd4, 5'd1));
    emit(rtype(7'd0, f3_and, 5'd6, 5'd5, 5'd3));
    emit(rtype(7'd0, f3_or, 5'd7, 5'd6, 5'd2));
    emit(itype(f3_add, 5'd8, 5'd7, -12'd5));
    emit(rtype(7'd0, f3_slt, 5'd9, 5'd8, 5'd7));
    emit(itype(f3_slt, 5'd10, 5'd9, 12'h002));
    emit(rtype(7'd0, f3_sll, 5'd11, 5'd7, 5'd10));
    emit(utype(5'd12, 20'h80000));
    emit(rtype(7'd0, f3_srl, 5'd13, 5'd12, 5'd10));
    emit(rtype(7'd0, f3_slt, 5'd14, 5'd12, 5'd13));
    emit(itype(f3_and, 5'd15, 5'd11, 12'h7f0));
    emit(itype(f3_or, 5'd16, 5'd15, -12'd256));
    // Result goes nowhere, then x0 is read back
    emit(itype(f3_xor, 5'd0, 5'd16, 12'h055));
    emit(rtype(7'd0, f3_add, 5'd17, 5'd0, 5'd16));
endtask

task automatic load_mem_test();
    clear_rom();
    emit(itype(f3_add, 5'd1, 5'd0, 12'h040));
    emit(itype(f3_add, 5'd2, 5'd0, 12'h123));
    emit(utype(5'd3, 20'habcde));
    emit(itype(f3_add, 5'd3, 5'd3, 12'h765));
    emit(sw_inst(5'd2, 5'd1, 12'd0));
    emit(sw_inst(5'd3, 5'd1, 12'd4));
    emit(rtype(7'd0, f3_add, 5'd4, 5'd2, 5'd3));
    emit(sw_inst(5'd4, 5'd1, 12'd12));
    emit(sw_inst(5'd1, 5'd1, -12'd8));
    emit(lw_inst(5'd5, 5'd1, 12'd4));
    emit(rtype(7'd0, f3_add, 5'd6, 5'd5, 5'd2));
    emit(lw_inst(5'd7, 5'd1, 12'd12));
    emit(lw_inst(5'd8, 5'd1, 12'd0));
    emit(rtype(f7_alt, f3_add, 5'd9, 5'd8, 5'd7));
    emit(lw_inst(5'd10, 5'd1, 12'd32));
    emit(rtype(7'd0, f3_xor, 5'd11, 5'd10, 5'd6));
    emit(sw_inst(5'd11, 5'd1, 12'd16));
    emit(lw_inst(5'd12, 5'd1, 12'd16));
    emit(lw_inst(5'd13, 5'd1, -12'd8));
endtask

task automatic load_branch_test();
    clear_rom();
    emit(itype(f3_add, 5'd1, 5'd0, 12'd3));
    emit(itype(f3_add, 5'd2, 5'd0, 12'd0));
    // Counted loop
    emit(itype(f3_add, 5'd2, 5'd2, 12'd5));
    emit(itype(f3_add, 5'd1, 5'd1, -12'd1));
    emit(btype(f3_bne, 5'd1, 5'd0, -13'd8));
    emit(btype(f3_beq, 5'd2, 5'd0, 13'd8));
    emit(itype(f3_add, 5'd3, 5'd0, 12'd1));
    emit(btype(f3_beq, 5'd2, 5'd2, 13'd8));
    emit(itype(f3_add, 5'd3, 5'd0, 12'd99));
    emit(btype(f3_blt, 5'd1, 5'd2, 13'd8));
    emit(itype(f3_add, 5'd4, 5'd0, 12'd77));
    emit(btype(f3_blt, 5'd2, 5'd1, 13'd8));
    emit(itype(f3_add, 5'd5, 5'd0, -12'd1));
    emit(btype(f3_blt, 5'd5, 5'd1, 13'd8));
    emit(itype(f3_add, 5'd6, 5'd0, 12'd1));
    emit(btype(f3_bne, 5'd5, 5'd5, 13'd8));
    emit(itype(f3_add, 5'd7, 5'd2, 12'd1));
    emit(btype(f3_beq, 5'd0, 5'd0, 13'd8));
    emit(itype(f3_add, 5'd8, 5'd0, 12'd5));
    emit(rtype(7'd0, f3_add, 5'd9, 5'd7, 5'd3));
endtask

task automatic load_random_ops();
    logic [31:0] bits;
    logic [2:0]  f3;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    clear_rom();
    for (int r = 1; r < 8; r++) begin
        bits = take_bits(32);
        emit(utype(reg_idx_t'(r), bits[31:12]));
        emit(itype(f3_add, reg_idx_t'(r), reg_idx_t'(r), bits[11:0]));
    end
    // Bits 24 type, 23:21 funct3, 20:12 registers, 11:0 immediate
    for (int n = 0; n < 40; n++) begin
        bits = take_bits(25);
        f3   = bits[23:21];
        rd   = {2'b00, bits[20:18]};
        rs1  = {2'b00, bits[17:15]};
        rs2  = {2'b00, bits[14:12]};
        if (!bits[24]) begin
            if (f3 == 3'b011) begin
                emit(rtype(f7_alt, f3_add, rd, rs1, rs2));
            end else begin
                emit(rtype(7'd0, f3, rd, rs1, rs2));
            end
        end else begin
            // Shift and unsigned encodings fold onto addi, slti, xori
            if (f3[0] && f3 != 3'b111) begin
                f3[0] = 1'b0;
            end
            emit(itype(f3, rd, rs1, bits[11:0]));
        end
    end
endtask

// File: tb/tb_rv_core.sv
// RV32I core testbench
`timescale 1ns/10ps
`include "rv_cfg.svh"

module tb_rv_core import rv_pkg::*; ();

    logic     clk;
    logic     arst_n;
    inst_t    irom_inst;
    word_t    irom_addr;
    word_t    dram_rdata;
    word_t    dram_addr;
    word_t    dram_wdata;
    logic     dram_we;
    logic     wb_have;
    word_t    wb_pc;
    logic     wb_ena;
    reg_idx_t wb_reg;
    word_t    wb_value;

    inst_t       rom [256];
    word_t       ram [256];
    word_t       model_ram [256];
    word_t       model_rf [32];
    int          prog_len;
    logic [31:0] lfsr;
    int          cycles;
    int          cycle_limit;

    // Expected retire trace
    word_t    exp_pc [$];
    logic     exp_ena [$];
    reg_idx_t exp_reg [$];
    word_t    exp_val [$];

    // Expected data RAM writes, in program order
    word_t    exp_st_addr [$];
    word_t    exp_st_data [$];

    rv_core dut0 (
        .clk_cpu_i            (clk),
        .arst_n_i             (arst_n),
        .irom_inst_i          (irom_inst),
        .dram_rdata_i         (dram_rdata),
        .irom_addr_o          (irom_addr),
        .dram_addr_o          (dram_addr),
        .dram_wdata_o         (dram_wdata),
        .dram_we_o            (dram_we),
        .debug_wb_have_inst_o (wb_have),
        .debug_wb_pc_o        (wb_pc),
        .debug_wb_ena_o       (wb_ena),
        .debug_wb_reg_o       (wb_reg),
        .debug_wb_value_o     (wb_value)
    );

    //////////////////////////////
    // Clock, memories, watchdog
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign irom_inst  = rom[irom_addr[9:2]];
    assign dram_rdata = ram[dram_addr[9:2]];

    always @(posedge clk) begin
        if (dram_we) begin
            ram[dram_addr[9:2]] <= dram_wdata;
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("Timeout: run stopped after %0d cycles", cycles);
                abort_run();
            end
        end
    end

    //////////////////////////////
    // Helpers and checks
    //////////////////////////////

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t fill_word(logic [7:0] idx);
        return 32'h9e37_79b9 * (32'(idx) + 32'd1);
    endfunction

    task automatic clear_rom();
        for (int i = 0; i < 256; i++) begin
            rom[i[7:0]] = {12'h000, 5'd0, 3'b000, 5'd0, `RV_OP_OP_IMM};
        end
        prog_len = 0;
    endtask

    task automatic emit(inst_t inst);
        rom[prog_len[7:0]] = inst;
        prog_len = prog_len + 1;
    endtask

    `include "tb_programs.svh"

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model();
        word_t pc;
        word_t next;
        word_t addr;
        word_t a;
        word_t b;
        word_t res;
        inst_t in;
        logic  wr;
        logic  take;
        int    steps;
        exp_pc.delete();
        exp_ena.delete();
        exp_reg.delete();
        exp_val.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        pc    = `RV_RESET_PC;
        steps = 0;
        while (pc != word_t'(prog_len * 4)) begin
            if (steps > 500) begin
                $display("Reference model never reached the end of the program");
                abort_run();
            end
            in   = rom[pc[9:2]];
            a    = model_rf[in[19:15]];
            b    = model_rf[in[24:20]];
            res  = '0;
            wr   = 1'b1;
            take = 1'b0;
            next = pc + 32'd4;
            case (in[6:0])
                `RV_OP_OP:     res = alu_ref(in[14:12], in[30], a, b);
                `RV_OP_OP_IMM: res = alu_ref(in[14:12], 1'b0, a, {{20{in[31]}}, in[31:20]});
                `RV_OP_LUI:    res = {in[31:12], 12'h000};
                `RV_OP_LOAD: begin
                    addr = a + {{20{in[31]}}, in[31:20]};
                    res  = model_ram[addr[9:2]];
                end
                `RV_OP_STORE: begin
                    wr   = 1'b0;
                    addr = a + {{20{in[31]}}, in[31:25], in[11:7]};
                    model_ram[addr[9:2]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                `RV_OP_BRANCH: begin
                    wr = 1'b0;
                    case (in[14:12])
                        3'b000:  take = (a == b);
                        3'b001:  take = (a != b);
                        default: take = ($signed(a) < $signed(b));
                    endcase
                    if (take) begin
                        next = pc + {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && in[11:7] != 5'd0) begin
                model_rf[in[11:7]] = res;
            end
            exp_pc.push_back(pc);
            exp_ena.push_back(wr);
            exp_reg.push_back(in[11:7]);
            exp_val.push_back(res);
            pc = next;
            steps++;
        end
    endtask

    //////////////////////////////
    // Test sequencing
    //////////////////////////////

    task automatic check_idle();
        check_bit("debug_wb_have_inst_o", wb_have, 1'b0);
        check_bit("debug_wb_ena_o", wb_ena, 1'b0);
        check_bit("dram_we_o", dram_we, 1'b0);
        check_word("irom_addr_o", irom_addr, `RV_RESET_PC);
    endtask

    task automatic start_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
    endtask

    task automatic finish_reset();
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_idle();
    endtask

    // Compares the retire trace and the RAM writes in order against the model
    task automatic check_program(string name);
        int k;
        int s;
        run_model();
        cycle_limit = cycle_limit + 4 * exp_pc.size();
        k = 0;
        s = 0;
        while (k < exp_pc.size()) begin
            @(negedge clk);
            if (dram_we) begin
                if (s >= exp_st_addr.size()) begin
                    $display("Data RAM written by an instruction that stores nothing");
                    abort_run();
                end
                check_word("dram_addr_o", dram_addr, exp_st_addr[s]);
                check_word("dram_wdata_o", dram_wdata, exp_st_data[s]);
                s++;
            end
            if (wb_have) begin
                check_word("debug_wb_pc_o", wb_pc, exp_pc[k]);
                check_bit("debug_wb_ena_o", wb_ena, exp_ena[k]);
                if (exp_ena[k]) begin
                    check_reg("debug_wb_reg_o", wb_reg, exp_reg[k]);
                    check_word("debug_wb_value_o", wb_value, exp_val[k]);
                end
                k++;
            end
        end
        if (s != exp_st_addr.size()) begin
            $display("Only %0d of %0d stores reached the data RAM", s, exp_st_addr.size());
            abort_run();
        end
        $display("%s: %0d instructions retired", name, k);
    endtask

    task automatic test_alu_chain();
        start_reset();
        load_alu_chain();
        finish_reset();
        check_program("alu chain");
    endtask

    task automatic test_load_store();
        start_reset();
        load_mem_test();
        finish_reset();
        check_program("load store");
        for (int i = 0; i < 256; i++) begin
            check_word($sformatf("ram[%0d]", i), ram[i[7:0]], model_ram[i[7:0]]);
        end
    endtask

    task automatic test_branches();
        start_reset();
        load_branch_test();
        finish_reset();
        check_program("branches");
    endtask

    task automatic test_random_ops();
        start_reset();
        load_random_ops();
        finish_reset();
        check_program("random ops");
    endtask

    initial begin
        arst_n      = 1'b0;
        lfsr        = 32'hd28d_a9a9;
        cycle_limit = 200;
        clear_rom();
        for (int i = 0; i < 256; i++) begin
            ram[i[7:0]]       <= fill_word(i[7:0]);
            model_ram[i[7:0]] = fill_word(i[7:0]);
        end
        for (int i = 0; i < 32; i++) begin
            model_rf[i[4:0]] = '0;
        end
        test_alu_chain();
        test_load_store();
        test_branches();
        test_random_ops();
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
+incdir+tb
hw/rv_pkg.sv
hw/rv_stage_if.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_mem_wb.sv
hw/rv_core.sv
tb/tb_rv_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0 --timescale 1ns/10ps
TOP       = tb_rv_core
FILELIST  = list.f
OBJDIR    = obj_dir
SOURCES   = $(wildcard hw/*.sv hw/*.svh tb/*.sv tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# A failing test ends in $fatal, which gives a nonzero exit status
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
